// File: verilog/cpu_pkg.sv
// Sizes and encodings for the execute slice with opcode values fixed by the issue side
package cpu_pkg;

    localparam int word_w     = 32;         // Data path width
    localparam int reg_addr_w = 5;          // 32 general registers

    typedef logic [word_w-1:0]     word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // Compact opcode as presented by issue
    typedef enum logic [3:0] {
        op_nop  = 4'd0,                     // No instruction
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_and  = 4'd3,
        op_or   = 4'd4,
        op_xor  = 4'd5,
        op_shl  = 4'd6,
        op_shr  = 4'd7,
        op_addi = 4'd8,                     // ra + imm
        op_slt  = 4'd9,                     // Signed set-less-than
        op_ld   = 4'd10,
        op_st   = 4'd11,
        op_beq  = 4'd12,
        op_bne  = 4'd13,
        op_blt  = 4'd14,
        op_jal  = 4'd15                     // Jump and link
    } op_e;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_shl = 3'd5,
        alu_shr = 3'd6                      // Logical, amount from low 5 bits
    } alu_op_e;

    typedef enum logic [1:0] {
        cmp_none = 2'd0,                    // Never true
        cmp_eq   = 2'd1,
        cmp_ne   = 2'd2,
        cmp_lt   = 2'd3                     // Signed
    } cmp_op_e;

    typedef enum logic [1:0] {
        mem_none  = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_op_e;

    // Source of the EX result
    typedef enum logic [1:0] {
        ex_out_alu = 2'd0,
        ex_out_cmp = 2'd1,                  // Compare bit zero-extended
        ex_out_pcn = 2'd2                   // Link value pc + 4
    } ex_out_sel_e;

endpackage

// File: verilog/id_ex_if.sv
// ID/EX register contents as seen by the execute stage with all fields driven from flops
interface id_ex_if;

    logic                   en;             // Valid instruction in EX
    cpu_pkg::alu_op_e       alu_op;
    cpu_pkg::word_t         alu_in_0;       // Before MEM forwarding
    cpu_pkg::word_t         alu_in_1;
    cpu_pkg::cmp_op_e       cmp_op;
    cpu_pkg::word_t         cmp_in_0;
    cpu_pkg::word_t         cmp_in_1;
    cpu_pkg::mem_op_e       mem_op;
    cpu_pkg::word_t         mem_wr_data;    // Store data before forwarding
    cpu_pkg::reg_addr_t     dst_addr;
    logic                   gpr_we_;        // Active low write enable
    cpu_pkg::ex_out_sel_e   ex_out_sel;
    cpu_pkg::word_t         link_data;      // pc + 4 for jal

    // Register side
    modport src (
        output en, alu_op, alu_in_0, alu_in_1, cmp_op, cmp_in_0, cmp_in_1,
               mem_op, mem_wr_data, dst_addr, gpr_we_, ex_out_sel, link_data
    );

    // Execute side
    modport dst (
        input  en, alu_op, alu_in_0, alu_in_1, cmp_op, cmp_in_0, cmp_in_1,
               mem_op, mem_wr_data, dst_addr, gpr_we_, ex_out_sel, link_data
    );

endinterface

// File: verilog/alu.sv
// Combinational ALU with no overflow flag and shifts using only the low 5 bits of arg1
module alu (
    input  cpu_pkg::word_t      arg0,
    input  cpu_pkg::word_t      arg1,
    input  cpu_pkg::alu_op_e    op,
    output cpu_pkg::word_t      val
);

    logic [4:0] shamt;

    assign shamt = arg1[4:0];                   // Shift amount

    always_comb begin
        case (op)
            cpu_pkg::alu_add: val = arg0 + arg1;   // Wraps
            cpu_pkg::alu_sub: val = arg0 - arg1;
            cpu_pkg::alu_and: val = arg0 & arg1;
            cpu_pkg::alu_or:  val = arg0 | arg1;
            cpu_pkg::alu_xor: val = arg0 ^ arg1;
            cpu_pkg::alu_shl: val = arg0 << shamt;
            cpu_pkg::alu_shr: val = arg0 >> shamt; // Zero fill
            default:          val = '0;
        endcase
    end

endmodule

// File: verilog/cmp.sv
// Combinational comparator where less-than is signed and cmp_none always reports false
module cmp (
    input  cpu_pkg::word_t      arg0,
    input  cpu_pkg::word_t      arg1,
    input  cpu_pkg::cmp_op_e    op,
    output logic                true
);

    always_comb begin
        case (op)
            cpu_pkg::cmp_eq: true = (arg0 == arg1);
            cpu_pkg::cmp_ne: true = (arg0 != arg1);
            cpu_pkg::cmp_lt: true = ($signed(arg0) < $signed(arg1));
            default:         true = 1'b0;       // No compare
        endcase
    end

endmodule

// File: verilog/ex_reg.sv
// EX/MEM register that holds on stall and ignores flush so a flushed slot arrives as a bubble
module ex_reg (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  cpu_pkg::word_t      ex_out_inner,   // Selected EX result
    input  logic                id_en,
    input  cpu_pkg::mem_op_e    id_mem_op,
    input  cpu_pkg::word_t      id_mem_wr_data,
    input  cpu_pkg::reg_addr_t  id_dst_addr,
    input  logic                id_gpr_we_,
    output logic                ex_en,
    output cpu_pkg::mem_op_e    ex_mem_op,
    output cpu_pkg::word_t      ex_mem_wr_data,
    output cpu_pkg::reg_addr_t  ex_dst_addr,
    output logic                ex_gpr_we_,
    output cpu_pkg::word_t      ex_out
);

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_en          <= 1'b0;
            ex_mem_op      <= cpu_pkg::mem_none;
            ex_mem_wr_data <= '0;
            ex_dst_addr    <= '0;
            ex_gpr_we_     <= 1'b1;             // No write
            ex_out         <= '0;
        end else if (!stall) begin
            ex_en          <= id_en;
            ex_mem_op      <= id_mem_op;
            ex_mem_wr_data <= id_mem_wr_data;
            ex_dst_addr    <= id_dst_addr;
            ex_gpr_we_     <= id_gpr_we_;
            ex_out         <= ex_out_inner;     // Address for ld/st
        end
    end

endmodule

// File: verilog/id_reg.sv
// ID/EX register with opcode decode where stall beats flush and upstream must hold issue on stall
module id_reg (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,          // Hold contents
    input  logic                flush,          // Load a bubble
    input  cpu_pkg::op_e        issue_op,
    input  cpu_pkg::word_t      issue_pc,
    input  cpu_pkg::word_t      issue_ra_data,
    input  cpu_pkg::word_t      issue_rb_data,
    input  cpu_pkg::word_t      issue_imm,
    input  cpu_pkg::reg_addr_t  issue_dst_addr,
    id_ex_if.src                id_ex
);

    logic                   dec_en;
    cpu_pkg::alu_op_e       dec_alu_op;
    cpu_pkg::word_t         dec_alu_in_0;
    cpu_pkg::word_t         dec_alu_in_1;
    cpu_pkg::cmp_op_e       dec_cmp_op;
    cpu_pkg::mem_op_e       dec_mem_op;
    cpu_pkg::word_t         dec_mem_wr_data;
    logic                   dec_gpr_we_;
    cpu_pkg::ex_out_sel_e   dec_ex_out_sel;

    // Decode with defaults describing a register add
    always_comb begin
        dec_en          = 1'b1;
        dec_alu_op      = cpu_pkg::alu_add;
        dec_alu_in_0    = issue_ra_data;
        dec_alu_in_1    = issue_rb_data;
        dec_cmp_op      = cpu_pkg::cmp_none;
        dec_mem_op      = cpu_pkg::mem_none;
        dec_mem_wr_data = '0;
        dec_gpr_we_     = 1'b0;                 // Writes a register
        dec_ex_out_sel  = cpu_pkg::ex_out_alu;
        case (issue_op)
            cpu_pkg::op_nop: begin
                dec_en      = 1'b0;
                dec_gpr_we_ = 1'b1;
            end
            cpu_pkg::op_sub:  dec_alu_op = cpu_pkg::alu_sub;
            cpu_pkg::op_and:  dec_alu_op = cpu_pkg::alu_and;
            cpu_pkg::op_or:   dec_alu_op = cpu_pkg::alu_or;
            cpu_pkg::op_xor:  dec_alu_op = cpu_pkg::alu_xor;
            cpu_pkg::op_shl:  dec_alu_op = cpu_pkg::alu_shl;
            cpu_pkg::op_shr:  dec_alu_op = cpu_pkg::alu_shr;
            cpu_pkg::op_addi: dec_alu_in_1 = issue_imm;
            cpu_pkg::op_slt: begin
                dec_cmp_op     = cpu_pkg::cmp_lt;
                dec_ex_out_sel = cpu_pkg::ex_out_cmp;
            end
            cpu_pkg::op_ld: begin
                dec_alu_in_1 = issue_imm;       // Address is ra + imm
                dec_mem_op   = cpu_pkg::mem_load;
            end
            cpu_pkg::op_st: begin
                dec_alu_in_1    = issue_imm;
                dec_mem_op      = cpu_pkg::mem_store;
                dec_mem_wr_data = issue_rb_data;
                dec_gpr_we_     = 1'b1;
            end
            cpu_pkg::op_beq, cpu_pkg::op_bne, cpu_pkg::op_blt: begin
                dec_alu_in_0 = issue_pc;        // Target is pc + imm
                dec_alu_in_1 = issue_imm;
                dec_gpr_we_  = 1'b1;
                dec_cmp_op   = (issue_op == cpu_pkg::op_beq) ? cpu_pkg::cmp_eq :
                               (issue_op == cpu_pkg::op_bne) ? cpu_pkg::cmp_ne :
                                                               cpu_pkg::cmp_lt;
            end
            cpu_pkg::op_jal: begin
                dec_alu_in_0   = issue_pc;
                dec_alu_in_1   = issue_imm;
                dec_ex_out_sel = cpu_pkg::ex_out_pcn;
            end
            default: ;                          // op_add
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || (flush && !stall)) begin   // Bubble
            id_ex.en          <= 1'b0;
            id_ex.alu_op      <= cpu_pkg::alu_add;
            id_ex.alu_in_0    <= '0;
            id_ex.alu_in_1    <= '0;
            id_ex.cmp_op      <= cpu_pkg::cmp_none;
            id_ex.cmp_in_0    <= '0;
            id_ex.cmp_in_1    <= '0;
            id_ex.mem_op      <= cpu_pkg::mem_none;
            id_ex.mem_wr_data <= '0;
            id_ex.dst_addr    <= '0;
            id_ex.gpr_we_     <= 1'b1;
            id_ex.ex_out_sel  <= cpu_pkg::ex_out_alu;
            id_ex.link_data   <= '0;
        end else if (!stall) begin
            id_ex.en          <= dec_en;
            id_ex.alu_op      <= dec_alu_op;
            id_ex.alu_in_0    <= dec_alu_in_0;
            id_ex.alu_in_1    <= dec_alu_in_1;
            id_ex.cmp_op      <= dec_cmp_op;
            id_ex.cmp_in_0    <= issue_ra_data;  // Compare always sees ra, rb
            id_ex.cmp_in_1    <= issue_rb_data;
            id_ex.mem_op      <= dec_mem_op;
            id_ex.mem_wr_data <= dec_mem_wr_data;
            id_ex.dst_addr    <= issue_dst_addr;
            id_ex.gpr_we_     <= dec_gpr_we_;
            id_ex.ex_out_sel  <= dec_ex_out_sel;
            id_ex.link_data   <= issue_pc + cpu_pkg::word_t'(4);
        end
    end

endmodule

// File: verilog/ex_stage.sv
// Execute stage where MEM forwarding reaches operand 0 and store data but never the comparator
module ex_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  logic                ex_ra_fwd_en,   // Take MEM data for operand 0
    input  logic                ex_rb_fwd_en,   // Take MEM data for store data
    input  cpu_pkg::word_t      mem_fwd_data,
    id_ex_if.dst                id_ex,
    output cpu_pkg::word_t      fwd_data,       // Result bypass
    output cpu_pkg::word_t      br_addr,
    output logic                br_taken,
    output logic                ex_en,
    output cpu_pkg::mem_op_e    ex_mem_op,
    output cpu_pkg::word_t      ex_mem_wr_data,
    output cpu_pkg::reg_addr_t  ex_dst_addr,
    output logic                ex_gpr_we_,
    output cpu_pkg::word_t      ex_out
);

    cpu_pkg::word_t alu_in_0;
    cpu_pkg::word_t alu_out;
    cpu_pkg::word_t mem_wr_data;
    cpu_pkg::word_t ex_out_inner;
    logic           cmp_out;
    logic           jump;

    // Forwarding muxes
    assign alu_in_0    = ex_ra_fwd_en ? mem_fwd_data : id_ex.alu_in_0;
    assign mem_wr_data = ex_rb_fwd_en ? mem_fwd_data : id_ex.mem_wr_data;

    alu alu_i (
        .arg0 (alu_in_0),
        .arg1 (id_ex.alu_in_1),                 // Immediate for ld/st and never forwarded
        .op   (id_ex.alu_op),
        .val  (alu_out)
    );

    cmp cmp_i (
        .arg0 (id_ex.cmp_in_0),
        .arg1 (id_ex.cmp_in_1),
        .op   (id_ex.cmp_op),
        .true (cmp_out)
    );

    // Result select
    always_comb begin
        case (id_ex.ex_out_sel)
            cpu_pkg::ex_out_alu: ex_out_inner = alu_out;
            cpu_pkg::ex_out_cmp: ex_out_inner = {{(cpu_pkg::word_w-1){1'b0}}, cmp_out};
            cpu_pkg::ex_out_pcn: ex_out_inner = id_ex.link_data;
            default:             ex_out_inner = '0;
        endcase
    end

    // Only jal selects the link value
    assign jump     = (id_ex.ex_out_sel == cpu_pkg::ex_out_pcn);
    assign fwd_data = ex_out_inner;
    assign br_addr  = alu_out;                  // pc + imm for branches and jal
    assign br_taken = id_ex.en & (cmp_out | jump);

    ex_reg ex_reg_i (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .ex_out_inner   (ex_out_inner),
        .id_en          (id_ex.en),
        .id_mem_op      (id_ex.mem_op),
        .id_mem_wr_data (mem_wr_data),          // After forwarding
        .id_dst_addr    (id_ex.dst_addr),
        .id_gpr_we_     (id_ex.gpr_we_),
        .ex_en          (ex_en),
        .ex_mem_op      (ex_mem_op),
        .ex_mem_wr_data (ex_mem_wr_data),
        .ex_dst_addr    (ex_dst_addr),
        .ex_gpr_we_     (ex_gpr_we_),
        .ex_out         (ex_out)
    );

endmodule

// File: verilog/ex_top.sv
// Execute slice top where stall, flush and forwarding enables come from an outside hazard unit
module ex_top (
    input  logic                clk,
    input  logic                reset,
    // Issue side, one instruction per cycle
    input  cpu_pkg::op_e        issue_op,
    input  cpu_pkg::word_t      issue_pc,
    input  cpu_pkg::word_t      issue_ra_data,
    input  cpu_pkg::word_t      issue_rb_data,
    input  cpu_pkg::word_t      issue_imm,
    input  cpu_pkg::reg_addr_t  issue_dst_addr,
    input  logic                stall,
    input  logic                flush,
    // Forwarding from MEM
    input  logic                ex_ra_fwd_en,
    input  logic                ex_rb_fwd_en,
    input  cpu_pkg::word_t      mem_fwd_data,
    output cpu_pkg::word_t      fwd_data,
    output cpu_pkg::word_t      br_addr,
    output logic                br_taken,
    // Toward MEM
    output logic                ex_en,
    output cpu_pkg::mem_op_e    ex_mem_op,
    output cpu_pkg::word_t      ex_mem_wr_data,
    output cpu_pkg::reg_addr_t  ex_dst_addr,
    output logic                ex_gpr_we_,
    output cpu_pkg::word_t      ex_out
);

    id_ex_if id_ex ();

    id_reg id_reg_i (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .flush          (flush),
        .issue_op       (issue_op),
        .issue_pc       (issue_pc),
        .issue_ra_data  (issue_ra_data),
        .issue_rb_data  (issue_rb_data),
        .issue_imm      (issue_imm),
        .issue_dst_addr (issue_dst_addr),
        .id_ex          (id_ex.src)
    );

    ex_stage ex_stage_i (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .ex_ra_fwd_en   (ex_ra_fwd_en),
        .ex_rb_fwd_en   (ex_rb_fwd_en),
        .mem_fwd_data   (mem_fwd_data),
        .id_ex          (id_ex.dst),
        .fwd_data       (fwd_data),
        .br_addr        (br_addr),
        .br_taken       (br_taken),
        .ex_en          (ex_en),
        .ex_mem_op      (ex_mem_op),
        .ex_mem_wr_data (ex_mem_wr_data),
        .ex_dst_addr    (ex_dst_addr),
        .ex_gpr_we_     (ex_gpr_we_),
        .ex_out         (ex_out)
    );

endmodule

// File: tests/tb_ex_top.sv
// Random instruction stream from seed 794 checked against a two-entry ID/EX and EX/MEM model
module tb_ex_top;

    logic                   clk;
    logic                   reset;
    cpu_pkg::op_e           issue_op;
    cpu_pkg::word_t         issue_pc;
    cpu_pkg::word_t         issue_ra_data;
    cpu_pkg::word_t         issue_rb_data;
    cpu_pkg::word_t         issue_imm;
    cpu_pkg::reg_addr_t     issue_dst_addr;
    logic                   stall;
    logic                   flush;
    logic                   ex_ra_fwd_en;
    logic                   ex_rb_fwd_en;
    cpu_pkg::word_t         mem_fwd_data;
    cpu_pkg::word_t         fwd_data;
    cpu_pkg::word_t         br_addr;
    logic                   br_taken;
    logic                   ex_en;
    cpu_pkg::mem_op_e       ex_mem_op;
    cpu_pkg::word_t         ex_mem_wr_data;
    cpu_pkg::reg_addr_t     ex_dst_addr;
    logic                   ex_gpr_we_;
    cpu_pkg::word_t         ex_out;

    // Model of the ID/EX entry where op_nop is a bubble
    cpu_pkg::op_e           m_op;
    cpu_pkg::word_t         m_pc, m_ra, m_rb, m_imm;
    cpu_pkg::reg_addr_t     m_dst;
    // Model of EX/MEM
    logic                   e_en, e_we_;
    cpu_pkg::mem_op_e       e_mem_op;
    cpu_pkg::word_t         e_wr_data, e_out;
    cpu_pkg::reg_addr_t     e_dst;

    integer seed;
    integer issued;                         // Instructions drawn
    integer cycles;
    integer wait_cycles;
    integer r;
    logic   captured;                       // Last edge took the issue ports

    ex_top ex_top_i (
        .clk (clk), .reset (reset),
        .issue_op (issue_op), .issue_pc (issue_pc),
        .issue_ra_data (issue_ra_data), .issue_rb_data (issue_rb_data),
        .issue_imm (issue_imm), .issue_dst_addr (issue_dst_addr),
        .stall (stall), .flush (flush),
        .ex_ra_fwd_en (ex_ra_fwd_en), .ex_rb_fwd_en (ex_rb_fwd_en),
        .mem_fwd_data (mem_fwd_data),
        .fwd_data (fwd_data), .br_addr (br_addr), .br_taken (br_taken),
        .ex_en (ex_en), .ex_mem_op (ex_mem_op), .ex_mem_wr_data (ex_mem_wr_data),
        .ex_dst_addr (ex_dst_addr), .ex_gpr_we_ (ex_gpr_we_), .ex_out (ex_out)
    );

    always #4 clk = ~clk;                   // Period 8

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("mismatch at time %0t: %s is %h, expected %h",
                     $time, what, actual, expected);
            $display(">>> FAIL");
            $fatal(1, "output check failed");
        end
    endtask

    function automatic logic is_branch(input cpu_pkg::op_e op);
        return op == cpu_pkg::op_beq || op == cpu_pkg::op_bne || op == cpu_pkg::op_blt;
    endfunction

    // Ops whose first ALU operand is ra and so may take MEM forwarding
    function automatic logic uses_ra_operand(input cpu_pkg::op_e op);
        return (op >= cpu_pkg::op_add && op <= cpu_pkg::op_addi) ||
               op == cpu_pkg::op_ld || op == cpu_pkg::op_st;
    endfunction

    function automatic logic writes_reg(input cpu_pkg::op_e op);
        return (op >= cpu_pkg::op_add && op <= cpu_pkg::op_ld) || op == cpu_pkg::op_jal;
    endfunction

    function automatic logic compare_true(input cpu_pkg::op_e op, input cpu_pkg::word_t a,
                                          input cpu_pkg::word_t b);
        case (op)
            cpu_pkg::op_beq:                 return a == b;
            cpu_pkg::op_bne:                 return a != b;
            cpu_pkg::op_blt, cpu_pkg::op_slt: return $signed(a) < $signed(b);
            default:                         return 1'b0;
        endcase
    endfunction

    // EX result of the modelled entry with forwarding on operand 0
    function automatic cpu_pkg::word_t expected_result(input logic fa, input cpu_pkg::word_t md);
        cpu_pkg::word_t a0;
        a0 = fa ? md : ((is_branch(m_op) || m_op == cpu_pkg::op_jal) ? m_pc : m_ra);
        case (m_op)
            cpu_pkg::op_add: return a0 + m_rb;
            cpu_pkg::op_sub: return a0 - m_rb;
            cpu_pkg::op_and: return a0 & m_rb;
            cpu_pkg::op_or:  return a0 | m_rb;
            cpu_pkg::op_xor: return a0 ^ m_rb;
            cpu_pkg::op_shl: return a0 << m_rb[4:0];
            cpu_pkg::op_shr: return a0 >> m_rb[4:0];
            cpu_pkg::op_slt: return {31'b0, compare_true(m_op, m_ra, m_rb)};
            cpu_pkg::op_jal: return m_pc + 32'd4;     // Link value
            default:         return a0 + m_imm;       // addi, ld, st, branch target
        endcase
    endfunction

    task automatic draw_instruction();
        integer d;
        d                = $random(seed);
        issue_op         = cpu_pkg::op_e'(d[3:0]);
        issue_dst_addr   = d[8:4];
        issue_pc         = $random(seed);
        issue_pc[1:0]    = 2'b00;                     // Word aligned
        issue_ra_data    = $random(seed);
        if (d[12:11] == 2'b00)
            issue_rb_data = issue_ra_data;            // Equal operands for beq/bne now and then
        else
            issue_rb_data = $random(seed);
        issue_imm        = $random(seed);
    endtask

    task automatic check_outputs();
        logic valid;
        valid = (m_op != cpu_pkg::op_nop);
        check(32'(ex_en), 32'(e_en), "ex_en");
        check(32'(ex_gpr_we_), 32'(e_we_), "ex_gpr_we_");
        check(32'(ex_mem_op), 32'(e_mem_op), "ex_mem_op");
        if (e_en) begin
            check(ex_out, e_out, "ex_out");
            check(32'(ex_dst_addr), 32'(e_dst), "ex_dst_addr");
        end
        if (e_mem_op == cpu_pkg::mem_store)
            check(ex_mem_wr_data, e_wr_data, "ex_mem_wr_data");
        // Taken on a true compare or jal and never for a bubble
        check(32'(br_taken), 32'(valid && (compare_true(m_op, m_ra, m_rb) ||
              m_op == cpu_pkg::op_jal)), "br_taken");
        if (valid)
            check(fwd_data, expected_result(ex_ra_fwd_en, mem_fwd_data), "fwd_data");
        if (is_branch(m_op) || m_op == cpu_pkg::op_jal)
            check(br_addr, m_pc + m_imm, "br_addr");
    endtask

    // Model of the coming edge with EX/MEM first since it reads the old ID/EX entry
    task automatic advance_model();
        logic valid;
        valid = (m_op != cpu_pkg::op_nop);
        if (!stall) begin
            e_en      = valid;
            e_we_     = !(valid && writes_reg(m_op));
            e_mem_op  = (m_op == cpu_pkg::op_ld) ? cpu_pkg::mem_load :
                        (m_op == cpu_pkg::op_st) ? cpu_pkg::mem_store : cpu_pkg::mem_none;
            e_wr_data = ex_rb_fwd_en ? mem_fwd_data : m_rb;
            e_out     = expected_result(ex_ra_fwd_en, mem_fwd_data);
            e_dst     = m_dst;
            m_op      = flush ? cpu_pkg::op_nop : issue_op;
            m_pc      = issue_pc;
            m_ra      = issue_ra_data;
            m_rb      = issue_rb_data;
            m_imm     = issue_imm;
            m_dst     = issue_dst_addr;
        end
    endtask

    initial begin
        seed = 794;
        clk = 1'b0;
        reset = 1'b1;
        issue_op = cpu_pkg::op_nop;
        issue_pc = '0;
        issue_ra_data = '0;
        issue_rb_data = '0;
        issue_imm = '0;
        issue_dst_addr = '0;
        stall = 1'b0;
        flush = 1'b0;
        ex_ra_fwd_en = 1'b0;
        ex_rb_fwd_en = 1'b0;
        mem_fwd_data = '0;
        m_op = cpu_pkg::op_nop;               // Both model entries start as bubbles
        m_pc = '0;
        m_ra = '0;
        m_rb = '0;
        m_imm = '0;
        m_dst = '0;
        e_en = 1'b0;
        e_we_ = 1'b1;
        e_mem_op = cpu_pkg::mem_none;
        e_wr_data = '0;
        e_out = '0;
        e_dst = '0;
        issued = 0;
        cycles = 0;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
        wait_cycles = 0;
        while (!(ex_en === 1'b0 && ex_gpr_we_ === 1'b1) && wait_cycles < 16) begin
            @(posedge clk);
            #1 wait_cycles = wait_cycles + 1;
        end
        if (wait_cycles >= 16) begin
            $display("timeout: EX/MEM never showed a bubble after reset");
            $display(">>> FAIL");
            $fatal(1, "reset wait timed out");
        end
        captured = 1'b1;
        while (issued < 2000 && cycles < 20000) begin
            if (captured) begin                   // Upstream holds the issue ports on stall
                draw_instruction();
                issued = issued + 1;
            end
            r = $random(seed);
            stall        = (r[7:0] < 8'd51);          // About 20 percent
            flush        = (r[15:8] < 8'd26);         // About 10 percent
            ex_ra_fwd_en = r[16] && uses_ra_operand(m_op);
            ex_rb_fwd_en = r[17] && (m_op == cpu_pkg::op_st);
            mem_fwd_data = $random(seed);
            @(negedge clk);
            check_outputs();
            advance_model();
            captured = !stall;
            @(posedge clk);
            #1 cycles = cycles + 1;
        end
        if (issued < 2000) begin
            $display("timeout: instruction stream did not complete in %0d cycles", cycles);
            $display(">>> FAIL");
            $fatal(1, "run timed out");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// File: verilog.f
verilog/cpu_pkg.sv
verilog/id_ex_if.sv
verilog/alu.sv
verilog/cmp.sv
verilog/ex_reg.sv
verilog/id_reg.sv
verilog/ex_stage.sv
verilog/ex_top.sv
tests/tb_ex_top.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_ex_top -f verilog.f

out=$(./obj_dir/Vtb_ex_top || true)
echo "$out"

if echo "$out" | grep -Fxq '>>> PASS'; then
    exit 0
fi
exit 1
